/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_trigger_top
FILELIST = trigger_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/corr_config.svh */
`ifndef CORR_CONFIG_SVH
`define CORR_CONFIG_SVH

// Samples per frame per antenna
`define CORR_DEMUX 16
// Bits per sample, signed two's complement
`define CORR_NBITS 3
// Delay hypotheses searched by the peak finder
`define CORR_NDELAY 8
// Frames of history kept for antennas B and C
`define CORR_HIST 3
// Correlation value width, worst case 16 x 144 = 2304
`define CORR_VBITS 12

// Pipeline latencies in clock cycles
`define CORR_WIN_LAT 1
`define CORR_LAT 3
`define CORR_PEAK_LAT 3

`endif

/* design/corr_pkg.sv */
`include "corr_config.svh"

package corr_pkg;

	// One signed sample, -4 to 3
	typedef logic signed [`CORR_NBITS-1:0] sample_t;

	// One frame, sample j at bits 3j+2:3j
	typedef logic [`CORR_DEMUX*`CORR_NBITS-1:0] frame_t;

	// Frame history, index k counts back from the newest sample
	// Frame f position j sits at index 16f + j
	typedef logic [`CORR_HIST*`CORR_DEMUX*`CORR_NBITS-1:0] history_t;

	// Sum of squares for one delay hypothesis
	typedef logic [`CORR_VBITS-1:0] corr_t;

	// Index of a delay hypothesis
	typedef logic [$clog2(`CORR_NDELAY)-1:0] delay_idx_t;

	// Per-delay sample offsets into the B and C histories
	localparam int DELAY_OFS_B [`CORR_NDELAY] = '{0, 2, 4, 6, 8, 10, 12, 14};
	localparam int DELAY_OFS_C [`CORR_NDELAY] = '{0, 4, 8, 12, 16, 20, 24, 28};

	// Pick sample j out of a frame
	function automatic sample_t frame_sample(input frame_t f, input int j);
		return sample_t'(f[j*`CORR_NBITS +: `CORR_NBITS]);
	endfunction

	// Pick sample k out of a history, k = 0 is the newest
	function automatic sample_t hist_sample(input history_t h, input int k);
		return sample_t'(h[k*`CORR_NBITS +: `CORR_NBITS]);
	endfunction

endpackage

/* design/peak_finder.sv */
`include "corr_config.svh"

// Registered max tree over all delay hypotheses
// Right branch always holds the higher indices, so it wins ties
module peak_finder import corr_pkg::*; (
	input  logic       clk,
	input  logic       rst_i,
	input  corr_t      corr_value_i [`CORR_NDELAY],
	input  logic       corr_valid_i [`CORR_NDELAY],
	output corr_t      peak_value_o,
	output delay_idx_t peak_index_o,
	output logic       peak_valid_o
);

	// Survivors after each tree level
	localparam int N1 = `CORR_NDELAY / 2;
	localparam int N2 = N1 / 2;

	corr_t      val1_q [N1];
	delay_idx_t idx1_q [N1];
	corr_t      val2_q [N2];
	delay_idx_t idx2_q [N2];

	logic [`CORR_PEAK_LAT-1:0] vld_q;

	// Level 1: raw correlations in pairs, index comes from the position
	always_ff @(posedge clk) begin
		for (int m = 0; m < N1; m++) begin
			if (corr_value_i[2*m+1] >= corr_value_i[2*m]) begin
				val1_q[m] <= corr_value_i[2*m+1];
				idx1_q[m] <= delay_idx_t'(2 * m + 1);
			end else begin
				val1_q[m] <= corr_value_i[2*m];
				idx1_q[m] <= delay_idx_t'(2 * m);
			end
		end
	end

	// Level 2: winners carry their index along
	always_ff @(posedge clk) begin
		for (int m = 0; m < N2; m++) begin
			if (val1_q[2*m+1] >= val1_q[2*m]) begin
				val2_q[m] <= val1_q[2*m+1];
				idx2_q[m] <= idx1_q[2*m+1];
			end else begin
				val2_q[m] <= val1_q[2*m];
				idx2_q[m] <= idx1_q[2*m];
			end
		end
	end

	// Level 3: final pair straight into the outputs
	always_ff @(posedge clk) begin
		if (val2_q[1] >= val2_q[0]) begin
			peak_value_o <= val2_q[1];
			peak_index_o <= idx2_q[1];
		end else begin
			peak_value_o <= val2_q[0];
			peak_index_o <= idx2_q[0];
		end
	end

	// All correlators share one latency, so element 0 speaks for the set
	always_ff @(posedge clk) begin
		if (rst_i) begin
			vld_q <= '0;
		end else begin
			vld_q <= {vld_q[`CORR_PEAK_LAT-2:0], corr_valid_i[0]};
		end
	end

	assign peak_valid_o = vld_q[`CORR_PEAK_LAT-1];

endmodule

/* design/sample_window.sv */
`include "corr_config.svh"

// Input reorder and B/C frame history
module sample_window import corr_pkg::*; (
	input  logic     clk,
	input  logic     rst_i,
	input  logic     valid_i,
	input  frame_t   a_i,
	input  frame_t   b_i,
	input  frame_t   c_i,
	window_if.source win
);

	// Bits in one frame and in the frames that survive a shift
	localparam int FBITS = $bits(frame_t);
	localparam int KEEP_BITS = $bits(history_t) - FBITS;
	// Groups of four samples per frame
	localparam int NGRP = `CORR_DEMUX / 4;

	// Incoming frames carry the oldest sample of each group at the low position
	// Position 4g + j moves to 4g + 3 - j so that position 0 is the newest
	function automatic frame_t reorder(input frame_t f);
		frame_t r;
		for (int g = 0; g < NGRP; g++) begin
			for (int j = 0; j < 4; j++) begin
				r[(4*g+3-j)*`CORR_NBITS +: `CORR_NBITS] =
					f[(4*g+j)*`CORR_NBITS +: `CORR_NBITS];
			end
		end
		return r;
	endfunction

	// Reordered copies of this cycle's input
	frame_t a_reord;
	frame_t b_reord;
	frame_t c_reord;

	always_comb begin
		a_reord = reorder(a_i);
		b_reord = reorder(b_i);
		c_reord = reorder(c_i);
	end

	// Window valid follows valid_i by one cycle
	// Histories only age on a valid frame, so gaps leave them untouched
	always_ff @(posedge clk) begin
		if (rst_i) begin
			win.win_valid <= 1'b0;
			win.b_hist <= '0;
			win.c_hist <= '0;
		end else begin
			win.win_valid <= valid_i;
			if (valid_i) begin
				// New frame goes in at index 0, oldest frame drops off the top
				win.b_hist <= {win.b_hist[KEEP_BITS-1:0], b_reord};
				win.c_hist <= {win.c_hist[KEEP_BITS-1:0], c_reord};
			end
		end
	end

	// A is always aligned at offset 0, only the current frame is needed
	always_ff @(posedge clk) begin
		if (valid_i) begin
			win.a_frame <= a_reord;
		end
	end

endmodule

/* design/trigger_top.sv */
`include "corr_config.svh"

// Three-antenna coincidence trigger
// valid_i to valid_o is window + correlator + peak tree, 7 cycles
module trigger_top import corr_pkg::*; (
	input  logic       clk,
	input  logic       rst_i,
	input  logic       valid_i,
	input  frame_t     a_i,
	input  frame_t     b_i,
	input  frame_t     c_i,
	output logic       valid_o,
	output corr_t      peak_value_o,
	output delay_idx_t peak_index_o
);

	// Shared window from the reorder stage to all correlators
	window_if win ();

	// Per-delay results into the peak tree
	corr_t corr_value [`CORR_NDELAY];
	logic  corr_valid [`CORR_NDELAY];

	sample_window u_window (
		.clk     (clk),
		.rst_i   (rst_i),
		.valid_i (valid_i),
		.a_i     (a_i),
		.b_i     (b_i),
		.c_i     (c_i),
		.win     (win.source)
	);

	// One correlator per delay hypothesis, offsets from the package table
	for (genvar g = 0; g < `CORR_NDELAY; g++) begin : g_corr
		triple_correlator #(
			.OFS_B (DELAY_OFS_B[g]),
			.OFS_C (DELAY_OFS_C[g])
		) u_corr (
			.clk          (clk),
			.rst_i        (rst_i),
			.win          (win.sink),
			.corr_value_o (corr_value[g]),
			.corr_valid_o (corr_valid[g])
		);
	end

	peak_finder u_peak (
		.clk          (clk),
		.rst_i        (rst_i),
		.corr_value_i (corr_value),
		.corr_valid_i (corr_valid),
		.peak_value_o (peak_value_o),
		.peak_index_o (peak_index_o),
		.peak_valid_o (valid_o)
	);

endmodule

/* design/triple_correlator.sv */
`include "corr_config.svh"

// One delay hypothesis: sum over the frame of (a + b + c)^2
// Offsets up to 32 keep every B and C tap inside the three-frame history
module triple_correlator import corr_pkg::*; #(
	parameter int OFS_B = 0,
	parameter int OFS_C = 0
) (
	input  logic   clk,
	input  logic   rst_i,
	window_if.sink win,
	output corr_t  corr_value_o,
	output logic   corr_valid_o
);

	localparam int NS = `CORR_DEMUX;
	// Three samples of -4..3 add to -12..9, five bits signed
	localparam int SUM_BITS = `CORR_NBITS + 2;
	// Largest square is 144, eight bits unsigned
	localparam int SQ_BITS = 2 * SUM_BITS - 2;
	// Four squares, up to 576
	localparam int PART_BITS = SQ_BITS + 2;
	localparam int NGRP = NS / 4;

	// Stage 1 inputs, combinational
	logic signed [SUM_BITS-1:0]   sum_c  [NS];
	logic signed [2*SUM_BITS-1:0] prod_c [NS];

	// Pipeline registers
	logic [SQ_BITS-1:0]   sq_q   [NS];
	logic [PART_BITS-1:0] part_q [NGRP];
	logic [`CORR_LAT-1:0] vld_q;

	// Align B and C to A by the hypothesis offsets and square the sums
	always_comb begin
		for (int i = 0; i < NS; i++) begin
			sum_c[i] = SUM_BITS'(frame_sample(win.a_frame, i))
				+ SUM_BITS'(hist_sample(win.b_hist, i + OFS_B))
				+ SUM_BITS'(hist_sample(win.c_hist, i + OFS_C));
			prod_c[i] = sum_c[i] * sum_c[i];
		end
	end

	// Stage 1: register the squares
	// Square is never negative and fits in the low bits
	always_ff @(posedge clk) begin
		for (int i = 0; i < NS; i++) begin
			sq_q[i] <= prod_c[i][SQ_BITS-1:0];
		end
	end

	// Stage 2: four partial sums of four squares each
	always_ff @(posedge clk) begin
		for (int g = 0; g < NGRP; g++) begin
			part_q[g] <= PART_BITS'(sq_q[4*g])
				+ PART_BITS'(sq_q[4*g+1])
				+ PART_BITS'(sq_q[4*g+2])
				+ PART_BITS'(sq_q[4*g+3]);
		end
	end

	// Stage 3: final sum of the partials
	always_ff @(posedge clk) begin
		corr_value_o <= corr_t'(part_q[0])
			+ corr_t'(part_q[1])
			+ corr_t'(part_q[2])
			+ corr_t'(part_q[3]);
	end

	// Valid rides alongside the data, one bit per stage
	always_ff @(posedge clk) begin
		if (rst_i) begin
			vld_q <= '0;
		end else begin
			vld_q <= {vld_q[`CORR_LAT-2:0], win.win_valid};
		end
	end

	assign corr_valid_o = vld_q[`CORR_LAT-1];

endmodule

/* design/window_if.sv */
// Window handed from the sample window to every correlator
// Contents only move in a cycle with win_valid high
interface window_if import corr_pkg::*; ();

	// One new frame per cycle with this high
	logic     win_valid;
	// Reordered current A frame, position 0 newest
	frame_t   a_frame;
	// B and C histories, newest frame in the low bits
	history_t b_hist;
	history_t c_hist;

	// Driven by the sample window
	modport source (
		output win_valid,
		output a_frame,
		output b_hist,
		output c_hist
	);

	// Read by each correlator
	modport sink (
		input win_valid,
		input a_frame,
		input b_hist,
		input c_hist
	);

endinterface

/* dv/tb_trigger_top.sv */
module tb_trigger_top;
	timeunit 1ns;
	timeprecision 1ps;

	// Frame geometry and search space
	localparam int NS = 16;
	localparam int NHIST = 48;
	localparam int NDELAY = 8;
	// A sample that carries the planted pulse
	localparam int PULSE_POS = 1;
	// Valid pattern with back-to-back frames and gaps
	localparam logic [15:0] GAP_PATTERN = 16'b1101_0011_1110_0110;

	// Each drain is one idle cycle plus the pipeline and some slack
	localparam int DRAIN = 12;
	localparam int STIM_CYCLES = 4 + 12 + 16 + 4 + 32 + 64 + 5 * DRAIN;
	localparam int WATCHDOG_NS = (STIM_CYCLES + 7 + 20) * 100;

	logic        clk;
	logic        rst_i;
	logic        valid_i;
	logic [47:0] a_i;
	logic [47:0] b_i;
	logic [47:0] c_i;
	logic        valid_o;
	logic [11:0] peak_value_o;
	logic [2:0]  peak_index_o;

	// Reference histories with index 0 as the newest sample
	int b_ref [NHIST];
	int c_ref [NHIST];
	// Expected results in output order
	int exp_val_q [$];
	int exp_idx_q [$];

	int checks;
	int errors;
	int tests;
	int checks_at_start;
	int errors_at_start;

	trigger_top DUT (
		.clk          (clk),
		.rst_i        (rst_i),
		.valid_i      (valid_i),
		.a_i          (a_i),
		.b_i          (b_i),
		.c_i          (c_i),
		.valid_o      (valid_o),
		.peak_value_o (peak_value_o),
		.peak_index_o (peak_index_o)
	);

	always #50 clk = ~clk;

	// Groups of four arrive oldest first so position 4g + j swaps with 4g + 3 - j
	function automatic int rev_pos(input int p);
		return 4 * (p / 4) + 3 - (p % 4);
	endfunction

	// Signed sample p of a raw frame
	function automatic int sample_at(input logic [47:0] f, input int p);
		logic signed [2:0] s;
		s = f[3*p +: 3];
		return int'(s);
	endfunction

	function automatic logic [47:0] rand_frame();
		logic [63:0] r;
		r = {$urandom(), $urandom()};
		return r[47:0];
	endfunction

	// Raw frame with +3 where history index target lands inside the frame at base
	function automatic logic [47:0] pulse_frame(input int base, input int target);
		logic [47:0] f;
		int p;
		f = '0;
		p = target - base;
		if (p >= 0 && p < NS) begin
			f[3*rev_pos(p) +: 3] = 3'd3;
		end
		return f;
	endfunction

	// Advance the reference on one valid frame and queue the expected peak
	function automatic void model_push(input logic [47:0] a, input logic [47:0] b,
		input logic [47:0] c);
		int a_s [NS];
		int acc;
		int s;
		int best_val;
		int best_idx;
		for (int k = NHIST - 1; k >= NS; k--) begin
			b_ref[k] = b_ref[k-NS];
			c_ref[k] = c_ref[k-NS];
		end
		for (int p = 0; p < NS; p++) begin
			a_s[p] = sample_at(a, rev_pos(p));
			b_ref[p] = sample_at(b, rev_pos(p));
			c_ref[p] = sample_at(c, rev_pos(p));
		end
		best_val = -1;
		best_idx = 0;
		// B steps by 2 samples and C by 4 per delay and ties go to the later delay
		for (int d = 0; d < NDELAY; d++) begin
			acc = 0;
			for (int i = 0; i < NS; i++) begin
				s = a_s[i] + b_ref[i+2*d] + c_ref[i+4*d];
				acc += s * s;
			end
			if (acc >= best_val) begin
				best_val = acc;
				best_idx = d;
			end
		end
		exp_val_q.push_back(best_val);
		exp_idx_q.push_back(best_idx);
	endfunction

	task automatic send_frame(input logic [47:0] a, input logic [47:0] b,
		input logic [47:0] c);
		@(posedge clk);
		valid_i <= 1'b1;
		a_i <= a;
		b_i <= b;
		c_i <= c;
		model_push(a, b, c);
	endtask

	// Junk on the data lines must not reach the history
	task automatic send_idle();
		@(posedge clk);
		valid_i <= 1'b0;
		a_i <= rand_frame();
		b_i <= rand_frame();
		c_i <= rand_frame();
	endtask

	task automatic start_test();
		checks_at_start = checks;
		errors_at_start = errors;
	endtask

	// Wait until every queued result has come out and then report the test
	task automatic finish_test(input string name);
		send_idle();
		while (exp_val_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (2) @(posedge clk);
		tests++;
		$display("test %0d %s: %0d results checked, %0d errors", tests, name,
			checks - checks_at_start, errors - errors_at_start);
	endtask

	// Outputs settle after the rising edge so they are compared on the falling one
	always @(negedge clk) begin : check_results
		int ev;
		int ei;
		if (!rst_i && valid_o) begin
			if (exp_val_q.size() == 0) begin
				errors++;
				$display("valid_o went high with no result expected at %0t", $time);
			end else begin
				ev = exp_val_q.pop_front();
				ei = exp_idx_q.pop_front();
				checks++;
				assert (int'(peak_value_o) == ev) else begin
					errors++;
					$display("error peak_value_o got %h expected %h", peak_value_o, ev[11:0]);
				end
				assert (int'(peak_index_o) == ei) else begin
					errors++;
					$display("error peak_index_o got %h expected %h", peak_index_o, ei[2:0]);
				end
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired before all tests finished");
		$display("Simulation FAILED");
		$finish;
	end

	initial begin : main
		void'($urandom(32'hc7572125));
		clk = 1'b0;
		rst_i = 1'b1;
		valid_i = 1'b0;
		a_i = '0;
		b_i = '0;
		c_i = '0;
		checks = 0;
		errors = 0;
		tests = 0;
		for (int k = 0; k < NHIST; k++) begin
			b_ref[k] = 0;
			c_ref[k] = 0;
		end
		repeat (4) @(posedge clk);
		rst_i <= 1'b0;

		// Nothing valid in and nothing valid out
		start_test();
		repeat (12) send_idle();
		finish_test("idle after reset");

		start_test();
		for (int i = 0; i < 16; i++) begin
			if (GAP_PATTERN[i]) begin
				send_frame(rand_frame(), rand_frame(), rand_frame());
			end else begin
				send_idle();
			end
		end
		finish_test("latency with gaps");

		// All samples -4 give 16 x 144 on every delay
		start_test();
		repeat (4) send_frame({16{3'b100}}, {16{3'b100}}, {16{3'b100}});
		assert (exp_idx_q[$] == NDELAY - 1) else begin
			errors++;
			$display("equal correlations did not resolve to the highest delay");
		end
		finish_test("constant frames");

		// Oldest frame first so the last frame sent becomes history frame 0
		start_test();
		for (int k = 0; k < NDELAY; k++) begin
			for (int f = 2; f >= 0; f--) begin
				send_frame((f == 0) ? pulse_frame(0, PULSE_POS) : 48'h0,
					pulse_frame(NS * f, PULSE_POS + 2 * k),
					pulse_frame(NS * f, PULSE_POS + 4 * k));
			end
			assert (exp_idx_q[$] == k) else begin
				errors++;
				$display("planted pulse for delay %0d does not peak there", k);
			end
			send_idle();
		end
		finish_test("planted pulses");

		start_test();
		for (int i = 0; i < 64; i++) begin
			if ($urandom() % 3 != 0) begin
				send_frame(rand_frame(), rand_frame(), rand_frame());
			end else begin
				send_idle();
			end
		end
		finish_test("random frames");

		// Bound timing and range assertions count toward the total
		errors += DUT.u_props.fail_count;
		$display("%0d tests, %0d results checked, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* dv/trigger_properties.sv */
`include "corr_config.svh"

// Timing and range properties of the trigger top level
module trigger_properties (
	input logic       clk,
	input logic       rst_i,
	input logic       in_valid_i,
	input logic       out_valid_i,
	input logic [2:0] peak_index_i
);
	timeunit 1ns;
	timeprecision 1ps;

	// Window, correlator and peak tree in series
	localparam int IO_LAT = 7;

	// Failed assertions so far
	int fail_count = 0;

	// No result may leave during reset or in the cycle after it
	reset_quiet: assert property (@(posedge clk) $past(rst_i) |-> !out_valid_i)
		else begin
			fail_count++;
			$error("valid_o high during reset or in the cycle after it");
		end

	// One result per accepted frame after the fixed latency and none in the gaps
	fixed_latency: assert property (@(posedge clk) disable iff (rst_i)
		out_valid_i == $past(in_valid_i, IO_LAT))
		else begin
			fail_count++;
			$error("valid_o does not follow valid_i by the fixed latency");
		end

	// Reported index must be known and name an existing delay hypothesis
	index_range: assert property (@(posedge clk) disable iff (rst_i)
		out_valid_i |-> !$isunknown(peak_index_i) && int'(peak_index_i) < `CORR_NDELAY)
		else begin
			fail_count++;
			$error("peak_index_o unknown or out of range while valid_o is high");
		end

endmodule

// Attach to every instance of the trigger
bind trigger_top trigger_properties u_props (
	.clk          (clk),
	.rst_i        (rst_i),
	.in_valid_i   (valid_i),
	.out_valid_i  (valid_o),
	.peak_index_i (peak_index_o)
);

/* trigger_top.f */
+incdir+design
design/corr_pkg.sv
design/window_if.sv
design/sample_window.sv
design/triple_correlator.sv
design/peak_finder.sv
design/trigger_top.sv
dv/trigger_properties.sv
dv/tb_trigger_top.sv
